/* Bender.yml */
package:
  name: twdl_stage

sources:
  - src/twdl_pkg.sv
  - src/twdl_bus_if.sv
  - src/twdl_cfg_regs.sv
  - src/twdl_power_gen.sv
  - src/lane_fifo.sv
  - src/twdl_cmul.sv
  - src/twdl_stage_top.sv
  - target: test
    files:
      - bench/twdl_stage_chk.sv
      - bench/twdl_stage_tb.sv

/* bench/twdl_stage_chk.sv */
`timescale 1ns/10ps

module twdl_stage_chk (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic tw_valid,
	input logic smp_valid
);

	// failures seen, read by the testbench at the end
	int fails = 0;
	// in_valid history, bit k is k+1 edges old
	logic [twdl_pkg::PIPE_LAT-1:0] hist;

	always_ff @(posedge clk) begin
		if (!rst_n)
			hist <= '0;
		else
			hist <= {hist[twdl_pkg::PIPE_LAT-2:0], in_valid};
	end

	// fixed stream latency
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == hist[twdl_pkg::PIPE_LAT-1])
		else begin
			fails++;
			$error("out_valid does not follow in_valid by the pipeline latency");
		end

	// ack is a single pulse
	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else begin
			fails++;
			$error("wb_ack held for more than one cycle");
		end

	// ack only answers a strobe
	a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			fails++;
			$error("wb_ack without a preceding cyc and stb");
		end

	// samples never reach the multiplier ahead of their twiddles
	a_smp_tw: assert property (@(posedge clk) disable iff (!rst_n) smp_valid |-> tw_valid)
		else begin
			fails++;
			$error("smp_valid high while tw_valid is low");
		end

endmodule

bind twdl_stage_top twdl_stage_chk u_chk (
	.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
	.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.tw_valid(bus.tw_valid), .smp_valid(bus.smp_valid)
);

/* bench/twdl_stage_tb.sv */
`timescale 1ns/10ps

module twdl_stage_tb;

	localparam int DW = twdl_pkg::DATA_W;
	localparam int NL = twdl_pkg::LANES;
	// one lane in the expected word, re then im
	localparam int LW = 2 * DW;
	localparam int N_SMP = 200;
	// five bursts, gapped one about twice as long, plus drains
	localparam int TIMEOUT_CYC = 8 * N_SMP + 400;

	logic clk, rst_n, in_valid, out_valid;
	logic signed [DW-1:0] in_re [0:NL-1];
	logic signed [DW-1:0] in_im [0:NL-1];
	logic signed [DW-1:0] out_re [0:NL-1];
	logic signed [DW-1:0] out_im [0:NL-1];
	logic signed [twdl_pkg::TW_W-1:0] w_re, w_im;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [twdl_pkg::ADR_W-1:0] wb_adr;
	logic [twdl_pkg::WB_DW-1:0] wb_dat_i, wb_dat_o, rd_data;

	// expected outputs in issue order
	logic [NL*LW-1:0] exp_q [$];
	logic [NL*LW-1:0] exp_w;
	int tr [1:NL-1];
	int ti [1:NL-1];
	int seed, cycles, sent, checks, errors;
	bit cfg_inv, cfg_unity;
	twdl_pkg::radix_e cfg_radix;
	string test_name;

	twdl_stage_top dut (.*);

	always #5 clk = ~clk;

	// twiddle bits lo+15..lo of a product
	function automatic logic signed [15:0] tw_slice(input longint p, input int lo);
		return 16'(p >>> lo);
	endfunction

	// Q3.31 back to Q1.17, half up on the first dropped bit
	function automatic logic signed [DW-1:0] round_q117(input longint s);
		return DW'((s >>> 14) + ((s >>> 13) & 1));
	endfunction

	// W^1..W^4 for the current config
	task automatic build_powers(input int wr, input int wi);
		int ci;
		ci = cfg_inv ? -wi : wi;
		tr[1] = wr;
		ti[1] = ci;
		tr[2] = tw_slice(longint'(wr) * wr - longint'(ci) * ci, 14);
		ti[2] = tw_slice(longint'(wr) * ci, 13);
		if (cfg_radix == twdl_pkg::RADIX_2) begin
			tr[2] = twdl_pkg::TW_ONE;
			ti[2] = 0;
			tr[3] = tr[1];
			ti[3] = ti[1];
		end else begin
			tr[3] = tw_slice(longint'(tr[1]) * tr[2] - longint'(ti[1]) * ti[2], 14);
			ti[3] = tw_slice(longint'(tr[1]) * ti[2] + longint'(ti[1]) * tr[2], 14);
		end
		// W^4 squares W^2, override included
		tr[4] = tw_slice(longint'(tr[2]) * tr[2] - longint'(ti[2]) * ti[2], 14);
		ti[4] = tw_slice(longint'(tr[2]) * ti[2], 13);
		for (int k = 1; k < NL; k++) begin
			if (cfg_unity) begin
				tr[k] = twdl_pkg::TW_ONE;
				ti[k] = 0;
			end
		end
	endtask

	// one valid cycle plus its model result
	task automatic drive_sample(input bit full_scale);
		logic signed [DW-1:0] a, b;
		logic [NL*LW-1:0] word;
		int wr, wi;
		// |W| stays within one
		wr = $random(seed) % 11586;
		wi = $random(seed) % 11586;
		w_re = wr;
		w_im = wi;
		in_valid = 1'b1;
		build_powers(wr, wi);
		for (int k = 0; k < NL; k++) begin
			a = $random(seed);
			b = $random(seed);
			if (full_scale && ($random(seed) & 3) == 0)
				a = -(1 <<< (DW - 1));
			in_re[k] = a;
			in_im[k] = b;
			if (k == 0) begin
				word[0 +: LW] = {b, a};
			end else begin
				word[k*LW +: DW] = round_q117(longint'(a) * tr[k] - longint'(b) * ti[k]);
				word[k*LW+DW +: DW] = round_q117(longint'(a) * ti[k] + longint'(b) * tr[k]);
			end
		end
		exp_q.push_back(word);
		sent++;
	endtask

	task automatic run_burst(input int n, input bit gapped, input bit full_scale);
		int done;
		done = 0;
		while (done < n) begin
			if (gapped && ($random(seed) & 1)) begin
				in_valid = 1'b0;
			end else begin
				drive_sample(full_scale);
				done++;
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic wb_access(input bit we, input logic [1:0] adr, input logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = data;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		rd_data = wb_dat_o;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// ctrl write, then let the fifo flush settle
	task automatic set_config(input twdl_pkg::radix_e radix, input bit inv, input bit unity);
		cfg_radix = radix;
		cfg_inv = inv;
		cfg_unity = unity;
		wb_access(1'b1, twdl_pkg::CFG_CTRL, {27'd0, unity, inv, 3'(radix)});
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic wait_drain;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			assert (exp_q.size() > 0) else begin
				errors++;
				$display("%s: output valid with no sample outstanding", test_name);
			end
			if (exp_q.size() > 0) begin
				exp_w = exp_q.pop_front();
				checks++;
				for (int k = 0; k < NL; k++) begin
					assert (out_re[k] == exp_w[k*LW +: DW]) else begin
						errors++;
						$display("ERROR %s lane %0d re: expected %0d actual %0d",
							test_name, k, $signed(exp_w[k*LW +: DW]), out_re[k]);
					end
					assert (out_im[k] == exp_w[k*LW+DW +: DW]) else begin
						errors++;
						$display("ERROR %s lane %0d im: expected %0d actual %0d",
							test_name, k, $signed(exp_w[k*LW+DW +: DW]), out_im[k]);
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYC);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		w_re = '0;
		w_im = '0;
		for (int k = 0; k < NL; k++) begin
			in_re[k] = '0;
			in_im[k] = '0;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// same seed for tests 1 and 2, only the conjugation differs
		test_name = "fwd_radix4";
		seed = 17;
		set_config(twdl_pkg::RADIX_4, 1'b0, 1'b0);
		run_burst(N_SMP, 1'b0, 1'b0);
		wait_drain();
		test_name = "inverse";
		seed = 17;
		set_config(twdl_pkg::RADIX_4, 1'b1, 1'b0);
		run_burst(N_SMP, 1'b0, 1'b0);
		wait_drain();
		// W^2 forced to one, W on lane 3
		test_name = "radix2";
		set_config(twdl_pkg::RADIX_2, 1'b0, 1'b0);
		run_burst(N_SMP, 1'b0, 1'b0);
		wait_drain();
		test_name = "unity";
		set_config(twdl_pkg::RADIX_4, 1'b0, 1'b1);
		run_burst(N_SMP, 1'b0, 1'b1);
		wait_drain();
		test_name = "gapped";
		set_config(twdl_pkg::RADIX_3, 1'b1, 1'b0);
		run_burst(N_SMP, 1'b1, 1'b0);
		wait_drain();
		// counter runs since reset
		wb_access(1'b0, twdl_pkg::CFG_COUNT, '0);
		assert (rd_data[15:0] == 16'(sent)) else begin
			errors++;
			$display("ERROR %s count: expected %0d actual %0d", test_name, sent, rd_data[15:0]);
		end
		assert (checks == sent) else begin
			errors++;
			$display("%0d driven samples never came out", sent - checks);
		end
		$display("checks %0d, compare errors %0d, assertion failures %0d",
			checks, errors, dut.u_chk.fails);
		if (errors == 0 && dut.u_chk.fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* src/lane_fifo.sv */
`timescale 1ns/10ps

module lane_fifo #(
	parameter int DATA_W = twdl_pkg::DATA_W,
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic signed [DATA_W-1:0] wr_re [0:twdl_pkg::LANES-1],
	input logic signed [DATA_W-1:0] wr_im [0:twdl_pkg::LANES-1],
	input logic rd,
	input logic flush,
	twdl_bus_if.fifo bus
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// one word holds all five lanes
	logic signed [DATA_W-1:0] mem_re [0:DEPTH-1][0:twdl_pkg::LANES-1];
	logic signed [DATA_W-1:0] mem_im [0:DEPTH-1][0:twdl_pkg::LANES-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// pointers, wrap at DEPTH
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	// storage write
	always_ff @(posedge clk) begin
		if (wr) begin
			for (int k = 0; k < twdl_pkg::LANES; k++) begin
				mem_re[wr_ptr][k] <= wr_re[k];
				mem_im[wr_ptr][k] <= wr_im[k];
			end
		end
	end

	// read valid, one edge after the request
	always_ff @(posedge clk) begin
		if (!rst_n)
			bus.smp_valid <= 1'b0;
		else
			bus.smp_valid <= rd && !flush;
	end

	// registered read data
	always_ff @(posedge clk) begin
		if (rd) begin
			for (int k = 0; k < twdl_pkg::LANES; k++) begin
				bus.smp_re[k] <= mem_re[rd_ptr][k];
				bus.smp_im[k] <= mem_im[rd_ptr][k];
			end
		end
	end

endmodule

/* src/twdl_bus_if.sv */
`timescale 1ns/10ps

interface twdl_bus_if #(
	parameter int DATA_W = twdl_pkg::DATA_W,
	parameter int TW_W = twdl_pkg::TW_W
);

	// twiddle powers W^1..W^4, no entry for lane 0
	logic tw_valid;
	logic signed [TW_W-1:0] tw_re [1:twdl_pkg::LANES-1];
	logic signed [TW_W-1:0] tw_im [1:twdl_pkg::LANES-1];

	// lane samples read back from the fifo, aligned with the twiddles
	logic smp_valid;
	logic signed [DATA_W-1:0] smp_re [0:twdl_pkg::LANES-1];
	logic signed [DATA_W-1:0] smp_im [0:twdl_pkg::LANES-1];

	// power generator side
	modport gen (
		output tw_valid, tw_re, tw_im
	);

	// fifo read side
	modport fifo (
		output smp_valid, smp_re, smp_im
	);

	// multiplier takes both
	modport mul (
		input tw_valid, tw_re, tw_im, smp_valid, smp_re, smp_im
	);

endinterface

/* src/twdl_cfg_regs.sv */
`timescale 1ns/10ps

module twdl_cfg_regs (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [twdl_pkg::ADR_W-1:0] wb_adr,
	input logic [twdl_pkg::WB_DW-1:0] wb_dat_i,
	input logic out_valid,
	output logic [twdl_pkg::WB_DW-1:0] wb_dat_o,
	output logic wb_ack,
	output twdl_pkg::radix_e radix,
	output logic inverse,
	output logic unity,
	output logic flush
);

	logic req;
	logic ctrl_wr;
	logic [twdl_pkg::CNT_W-1:0] count;

	// new request, ack not yet given
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign ctrl_wr = req && wb_we && (wb_adr == twdl_pkg::CFG_CTRL);

	// single cycle ack, control fields, flush pulse, sample count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			radix <= twdl_pkg::RADIX_4;
			inverse <= 1'b0;
			unity <= 1'b0;
			flush <= 1'b0;
			count <= '0;
		end else begin
			wb_ack <= req;
			flush <= ctrl_wr;
			if (ctrl_wr) begin
				// unsupported radix codes keep the old value
				if (wb_dat_i[2:0] >= 3'd2 && wb_dat_i[2:0] <= 3'd5)
					radix <= twdl_pkg::radix_e'(wb_dat_i[2:0]);
				inverse <= wb_dat_i[twdl_pkg::CTRL_INV_BIT];
				unity <= wb_dat_i[twdl_pkg::CTRL_UNITY_BIT];
			end
			if (out_valid)
				count <= count + 1'b1;
		end
	end

	// read data, registered along with the ack
	always_ff @(posedge clk) begin
		if (req) begin
			case (twdl_pkg::cfg_addr_e'(wb_adr))
				twdl_pkg::CFG_CTRL:
					wb_dat_o <= {{(twdl_pkg::WB_DW-5){1'b0}}, unity, inverse, radix};
				twdl_pkg::CFG_COUNT:
					wb_dat_o <= {{(twdl_pkg::WB_DW-twdl_pkg::CNT_W){1'b0}}, count};
				default:
					wb_dat_o <= '0;
			endcase
		end
	end

endmodule

/* src/twdl_cmul.sv */
`timescale 1ns/10ps

module twdl_cmul #(
	parameter int DATA_W = twdl_pkg::DATA_W,
	parameter int TW_W = twdl_pkg::TW_W
) (
	input logic clk,
	input logic rst_n,
	twdl_bus_if.mul bus,
	output logic out_valid,
	output logic signed [DATA_W-1:0] out_re [0:twdl_pkg::LANES-1],
	output logic signed [DATA_W-1:0] out_im [0:twdl_pkg::LANES-1]
);

	// Q1.17 * Q2.14 gives Q3.31
	localparam int PROD_W = DATA_W + TW_W;
	localparam int FRAC = twdl_pkg::TW_FRAC;
	localparam int MSB = DATA_W + FRAC - 1;
	localparam int NL = twdl_pkg::LANES;

	logic v1;
	logic signed [PROD_W-1:0] p_rr [1:NL-1];
	logic signed [PROD_W-1:0] p_ii [1:NL-1];
	logic signed [PROD_W-1:0] p_ri [1:NL-1];
	logic signed [PROD_W-1:0] p_ir [1:NL-1];
	logic signed [PROD_W:0] sum_re [1:NL-1];
	logic signed [PROD_W:0] sum_im [1:NL-1];
	logic signed [DATA_W-1:0] rnd_re [1:NL-1];
	logic signed [DATA_W-1:0] rnd_im [1:NL-1];
	logic signed [DATA_W-1:0] l0_re, l0_im;

	// two cycle valid pipe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v1 <= bus.smp_valid && bus.tw_valid;
			out_valid <= v1;
		end
	end

	// cycle 1, four partials per lane
	always_ff @(posedge clk) begin
		for (int k = 1; k < NL; k++) begin
			p_rr[k] <= bus.smp_re[k] * bus.tw_re[k];
			p_ii[k] <= bus.smp_im[k] * bus.tw_im[k];
			p_ri[k] <= bus.smp_re[k] * bus.tw_im[k];
			p_ir[k] <= bus.smp_im[k] * bus.tw_re[k];
		end
		l0_re <= bus.smp_re[0];
		l0_im <= bus.smp_im[0];
	end

	// combine, back to Q1.17, round half up on bit FRAC-1
	always_comb begin
		for (int k = 1; k < NL; k++) begin
			sum_re[k] = p_rr[k] - p_ii[k];
			sum_im[k] = p_ri[k] + p_ir[k];
			rnd_re[k] = sum_re[k][MSB:FRAC] + DATA_W'(sum_re[k][FRAC-1]);
			rnd_im[k] = sum_im[k][MSB:FRAC] + DATA_W'(sum_im[k][FRAC-1]);
		end
	end

	// cycle 2, output regs
	always_ff @(posedge clk) begin
		// lane 0 bypass, zeroed between samples
		out_re[0] <= v1 ? l0_re : '0;
		out_im[0] <= v1 ? l0_im : '0;
		for (int k = 1; k < NL; k++) begin
			out_re[k] <= rnd_re[k];
			out_im[k] <= rnd_im[k];
		end
	end

endmodule

/* src/twdl_pkg.sv */
package twdl_pkg;

	// lane sample component width, Q1.17
	localparam int DATA_W = 18;
	// twiddle component width, Q2.14
	localparam int TW_W = 16;
	// one lane per radix point, radix 5 at most
	localparam int LANES = 5;

	// fixed point rules for twiddles
	localparam int TW_FRAC = 14;
	localparam int TW_ONE = 16384;

	// in_valid to out_valid
	localparam int PIPE_LAT = 6;
	// in_valid to twiddles ready at the multiplier
	localparam int TW_LAT = 4;

	// wishbone side
	localparam int WB_DW = 32;
	localparam int ADR_W = 2;
	localparam int CNT_W = 16;

	// ctrl register layout, radix sits in bits 2:0
	localparam int CTRL_INV_BIT = 3;
	localparam int CTRL_UNITY_BIT = 4;

	typedef enum logic [2:0] {
		RADIX_2 = 3'd2,
		RADIX_3 = 3'd3,
		RADIX_4 = 3'd4,
		RADIX_5 = 3'd5
	} radix_e;

	// word addresses
	typedef enum logic [ADR_W-1:0] {
		CFG_CTRL = 2'd0,
		CFG_COUNT = 2'd1
	} cfg_addr_e;

endpackage

/* src/twdl_power_gen.sv */
`timescale 1ns/10ps

module twdl_power_gen #(
	parameter int TW_W = twdl_pkg::TW_W
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic signed [TW_W-1:0] w_re,
	input logic signed [TW_W-1:0] w_im,
	input twdl_pkg::radix_e radix,
	input logic inverse,
	input logic unity,
	output logic fifo_rd,
	twdl_bus_if.gen bus
);

	// product width, one guard bit for the sums
	localparam int PW = 2 * TW_W + 1;
	localparam int HI = twdl_pkg::TW_FRAC + TW_W - 1;
	localparam int LO = twdl_pkg::TW_FRAC;
	localparam logic signed [TW_W-1:0] ONE = TW_W'(twdl_pkg::TW_ONE);

	logic [twdl_pkg::TW_LAT-1:0] vld;
	logic rdx2;
	logic signed [TW_W-1:0] w1_re, w1_im, w1_d1_re, w1_d1_im;
	logic signed [TW_W-1:0] w1_d2_re, w1_d2_im;
	logic signed [2*TW_W-1:0] sq_rr, sq_ii, sq_ri;
	logic signed [PW-1:0] w2_sum;
	logic signed [TW_W-1:0] w2c_re, w2c_im, w2_re, w2_im, w2_d_re, w2_d_im;
	logic signed [2*TW_W-1:0] c_rr, c_ii, c_ri, c_ir, q_rr, q_ii, q_ri;
	logic signed [PW-1:0] w3_re_sum, w3_im_sum, w4_sum;
	logic signed [TW_W-1:0] w3c_re, w3c_im, w4c_re, w4c_im;

	assign rdx2 = (radix == twdl_pkg::RADIX_2);

	// valid follows the twiddle pipe, vld[k] is k edges after capture
	always_ff @(posedge clk) begin
		if (!rst_n)
			vld <= '0;
		else
			vld <= {vld[twdl_pkg::TW_LAT-2:0], in_valid};
	end
	assign bus.tw_valid = vld[twdl_pkg::TW_LAT-1];
	// fifo needs its request one edge ahead of the data
	assign fifo_rd = vld[twdl_pkg::TW_LAT-2];

	// stage 1, capture W, conjugate for ifft
	always_ff @(posedge clk) begin
		w1_re <= w_re;
		w1_im <= inverse ? -w_im : w_im;
	end

	// squares of W, cut down to W^2 inside stage 2
	assign sq_rr = w1_re * w1_re;
	assign sq_ii = w1_im * w1_im;
	assign sq_ri = w1_re * w1_im;

	// W^2, imag is 2*re*im so take it one bit lower
	assign w2_sum = sq_rr - sq_ii;
	assign w2c_re = rdx2 ? ONE : w2_sum[HI:LO];
	assign w2c_im = rdx2 ? '0 : sq_ri[HI-1:LO-1];

	// stage 2, hold W^2
	always_ff @(posedge clk) begin
		w2_re <= w2c_re;
		w2_im <= w2c_im;
		w1_d1_re <= w1_re;
		w1_d1_im <= w1_im;
	end

	// stage 3, W*W^2 and W^2*W^2 partials
	always_ff @(posedge clk) begin
		c_rr <= w1_d1_re * w2_re;
		c_ii <= w1_d1_im * w2_im;
		c_ri <= w1_d1_re * w2_im;
		c_ir <= w1_d1_im * w2_re;
		q_rr <= w2_re * w2_re;
		q_ii <= w2_im * w2_im;
		q_ri <= w2_re * w2_im;
		w1_d2_re <= w1_d1_re;
		w1_d2_im <= w1_d1_im;
		w2_d_re <= w2_re;
		w2_d_im <= w2_im;
	end

	assign w3_re_sum = c_rr - c_ii;
	assign w3_im_sum = c_ri + c_ir;
	assign w4_sum = q_rr - q_ii;
	// radix 2 puts W on lane 3
	assign w3c_re = rdx2 ? w1_d2_re : w3_re_sum[HI:LO];
	assign w3c_im = rdx2 ? w1_d2_im : w3_im_sum[HI:LO];
	assign w4c_re = w4_sum[HI:LO];
	assign w4c_im = q_ri[HI-1:LO-1];

	// stage 4, output regs, unity overrides every power
	always_ff @(posedge clk) begin
		bus.tw_re[1] <= unity ? ONE : w1_d2_re;
		bus.tw_im[1] <= unity ? '0 : w1_d2_im;
		bus.tw_re[2] <= unity ? ONE : w2_d_re;
		bus.tw_im[2] <= unity ? '0 : w2_d_im;
		bus.tw_re[3] <= unity ? ONE : w3c_re;
		bus.tw_im[3] <= unity ? '0 : w3c_im;
		bus.tw_re[4] <= unity ? ONE : w4c_re;
		bus.tw_im[4] <= unity ? '0 : w4c_im;
	end

endmodule

/* src/twdl_stage_top.sv */
`timescale 1ns/10ps

module twdl_stage_top #(
	parameter int DATA_W = twdl_pkg::DATA_W,
	parameter int TW_W = twdl_pkg::TW_W,
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	// sample stream
	input logic in_valid,
	input logic signed [DATA_W-1:0] in_re [0:twdl_pkg::LANES-1],
	input logic signed [DATA_W-1:0] in_im [0:twdl_pkg::LANES-1],
	input logic signed [TW_W-1:0] w_re,
	input logic signed [TW_W-1:0] w_im,
	output logic out_valid,
	output logic signed [DATA_W-1:0] out_re [0:twdl_pkg::LANES-1],
	output logic signed [DATA_W-1:0] out_im [0:twdl_pkg::LANES-1],
	// wishbone classic config port
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [twdl_pkg::ADR_W-1:0] wb_adr,
	input logic [twdl_pkg::WB_DW-1:0] wb_dat_i,
	output logic [twdl_pkg::WB_DW-1:0] wb_dat_o,
	output logic wb_ack
);

	twdl_pkg::radix_e radix;
	logic inverse;
	logic unity;
	logic flush;
	logic fifo_rd;

	// twiddles and aligned samples
	twdl_bus_if #(.DATA_W(DATA_W), .TW_W(TW_W)) bus ();

	twdl_cfg_regs u_cfg (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_i(wb_dat_i),
		.out_valid(out_valid),
		.wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
		.radix(radix), .inverse(inverse), .unity(unity), .flush(flush)
	);

	twdl_power_gen #(.TW_W(TW_W)) u_pow (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.w_re(w_re), .w_im(w_im),
		.radix(radix), .inverse(inverse), .unity(unity),
		.fifo_rd(fifo_rd), .bus(bus.gen)
	);

	// samples wait here while the powers are built
	lane_fifo #(.DATA_W(DATA_W), .DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .rst_n(rst_n),
		.wr(in_valid), .wr_re(in_re), .wr_im(in_im),
		.rd(fifo_rd), .flush(flush), .bus(bus.fifo)
	);

	twdl_cmul #(.DATA_W(DATA_W), .TW_W(TW_W)) u_cmul (
		.clk(clk), .rst_n(rst_n), .bus(bus.mul),
		.out_valid(out_valid), .out_re(out_re), .out_im(out_im)
	);

endmodule

/* twdl_stage.f */
src/twdl_pkg.sv
src/twdl_bus_if.sv
src/twdl_cfg_regs.sv
src/twdl_power_gen.sv
src/lane_fifo.sv
src/twdl_cmul.sv
src/twdl_stage_top.sv
bench/twdl_stage_chk.sv
bench/twdl_stage_tb.sv
